//--- tb.f
gemv_pkg.sv
gemv_x_buffer.sv
gemv_dot_tile.sv
gemv_acc_bank.sv
gemv_ctrl.sv
gemv_top.sv
tb_gemv.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_gemv
RTL_TOP    ?= gemv_top
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
FAIL_MSG   ?= test failed
PASS_MSG   ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_gemv.sv
`timescale 1ns/10ps
`default_nettype none

module tb_gemv;

    localparam int NUM_JOBS    = 12;
    localparam int ROW_TILES   = gemv_pkg::MAX_ROWS / gemv_pkg::TILE_LEN;
    // x, bias, weight and y transfers of the largest job
    localparam int WORST_XFERS = gemv_pkg::MAX_TILES + ROW_TILES +
                                 gemv_pkg::MAX_ROWS * gemv_pkg::MAX_TILES + ROW_TILES;
    localparam int CYCLE_LIMIT = 8 * WORST_XFERS * NUM_JOBS + 1000;
    localparam int X_STREAM    = 0;
    localparam int BIAS_STREAM = 1;
    localparam int W_STREAM    = 2;

    logic                      clk;
    logic                      rst;
    logic                      start;
    gemv_pkg::dim_t            rows;
    gemv_pkg::dim_t            cols;
    logic                      done;
    logic                      x_valid;
    gemv_pkg::tile_t           x_tile;
    logic                      x_ready;
    logic                      bias_valid;
    gemv_pkg::tile_t           bias_tile;
    logic                      bias_ready;
    logic                      w_valid;
    gemv_pkg::tile_t           w_tile;
    logic                      w_ready;
    logic                      y_valid;
    gemv_pkg::acc_tile_t       y_tile;
    gemv_pkg::tile_idx_t       y_tile_idx;
    logic                      y_ready;

    int seed = 40950;
    int cycle_count;
    int cur_rows;

    // Reference model storage
    gemv_pkg::data_t x_m    [gemv_pkg::MAX_COLS];
    gemv_pkg::data_t bias_m [gemv_pkg::MAX_ROWS];
    gemv_pkg::data_t w_m    [gemv_pkg::MAX_ROWS][gemv_pkg::MAX_COLS];
    gemv_pkg::acc_t  y_m    [gemv_pkg::MAX_ROWS];

    gemv_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .rows       (rows),
        .cols       (cols),
        .done       (done),
        .x_valid    (x_valid),
        .x_tile     (x_tile),
        .x_ready    (x_ready),
        .bias_valid (bias_valid),
        .bias_tile  (bias_tile),
        .bias_ready (bias_ready),
        .w_valid    (w_valid),
        .w_tile     (w_tile),
        .w_ready    (w_ready),
        .y_valid    (y_valid),
        .y_tile     (y_tile),
        .y_tile_idx (y_tile_idx),
        .y_ready    (y_ready)
    );

    always #10 clk = ~clk;

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    function automatic gemv_pkg::data_t rand_data();
        return gemv_pkg::data_t'($random(seed));
    endfunction

    // Padding rows of the last y tile hold the zero bias padding
    function automatic gemv_pkg::acc_t expected_y(input int r);
        if (r < cur_rows) begin
            return y_m[r];
        end
        return '0;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("test failed");
        $fatal(1, "Stopping at the first mismatch");
    endtask

    task automatic check_acc(input gemv_pkg::acc_t got, input gemv_pkg::acc_t exp,
                             input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("%s got %0d expected %0d", what, got, exp));
        end
    endtask

    task automatic check_idx(input gemv_pkg::tile_idx_t got, input gemv_pkg::tile_idx_t exp,
                             input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("%s got %0d expected %0d", what, got, exp));
        end
    endtask

    task automatic check_flag(input bit got, input bit exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("%s got %0b expected %0b", what, got, exp));
        end
    endtask

    // Offers one tile after a random gap and holds it until ready is seen
    task automatic send_tile(input int stream, input gemv_pkg::tile_t data);
        int gap;
        bit taken;
        gap = rand_below(3);
        repeat (gap) begin
            @(posedge clk);
            #2;
        end
        case (stream)
            X_STREAM: begin
                x_valid = 1'b1;
                x_tile  = data;
            end
            BIAS_STREAM: begin
                bias_valid = 1'b1;
                bias_tile  = data;
            end
            default: begin
                w_valid = 1'b1;
                w_tile  = data;
            end
        endcase
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            case (stream)
                X_STREAM:    taken = x_ready;
                BIAS_STREAM: taken = bias_ready;
                default:     taken = w_ready;
            endcase
            @(posedge clk);
            #2;
        end
        x_valid    = 1'b0;
        bias_valid = 1'b0;
        w_valid    = 1'b0;
    endtask

    // Receives all y tiles with random stalls and checks held data
    task automatic collect_y(input int n_tiles);
        int t;
        int stall;
        bit moved;
        bit held;
        gemv_pkg::tile_idx_t held_idx;
        gemv_pkg::acc_tile_t held_tile;
        held = 1'b0;
        for (t = 0; t < n_tiles; t++) begin
            stall = rand_below(4);
            moved = 1'b0;
            while (!moved) begin
                y_ready = (stall == 0);
                @(negedge clk);
                check_flag(done, 1'b0, "done before the last y transfer");
                if (held) begin
                    check_flag(y_valid, 1'b1, "y_valid dropped during a stall");
                    check_idx(y_tile_idx, held_idx, "y_tile_idx changed during a stall");
                    for (int i = 0; i < gemv_pkg::TILE_LEN; i++) begin
                        check_acc(y_tile[i], held_tile[i], "y_tile changed during a stall");
                    end
                end
                if (y_valid) begin
                    check_idx(y_tile_idx, gemv_pkg::tile_idx_t'(t), "y_tile_idx");
                    for (int i = 0; i < gemv_pkg::TILE_LEN; i++) begin
                        check_acc(y_tile[i], expected_y(t * gemv_pkg::TILE_LEN + i),
                                  $sformatf("y tile %0d lane %0d", t, i));
                    end
                    moved     = y_ready;
                    held      = !y_ready;
                    held_idx  = y_tile_idx;
                    held_tile = y_tile;
                    if (stall > 0) begin
                        stall--;
                    end
                end
                @(posedge clk);
                #2;
            end
        end
        y_ready = 1'b0;
    endtask

    task automatic run_job(input int n_rows, input int n_cols);
        int col_tiles;
        int row_tiles;
        int idx;
        int acc;
        gemv_pkg::tile_t tile;
        cur_rows  = n_rows;
        col_tiles = (n_cols + gemv_pkg::TILE_LEN - 1) / gemv_pkg::TILE_LEN;
        row_tiles = (n_rows + gemv_pkg::TILE_LEN - 1) / gemv_pkg::TILE_LEN;
        for (int c = 0; c < n_cols; c++) begin
            x_m[c] = rand_data();
        end
        for (int r = 0; r < n_rows; r++) begin
            bias_m[r] = rand_data();
            acc = int'(bias_m[r]);
            for (int c = 0; c < n_cols; c++) begin
                w_m[r][c] = rand_data();
                acc += int'(w_m[r][c]) * int'(x_m[c]);
            end
            y_m[r] = gemv_pkg::acc_t'(acc);
        end
        start = 1'b1;
        rows  = gemv_pkg::dim_t'(n_rows);
        cols  = gemv_pkg::dim_t'(n_cols);
        @(posedge clk);
        #2;
        start = 1'b0;
        // Lanes past cols carry random data that must be masked
        for (int t = 0; t < col_tiles; t++) begin
            for (int i = 0; i < gemv_pkg::TILE_LEN; i++) begin
                idx = t * gemv_pkg::TILE_LEN + i;
                tile[i] = (idx < n_cols) ? x_m[idx] : rand_data();
            end
            send_tile(X_STREAM, tile);
        end
        for (int t = 0; t < row_tiles; t++) begin
            for (int i = 0; i < gemv_pkg::TILE_LEN; i++) begin
                idx = t * gemv_pkg::TILE_LEN + i;
                tile[i] = (idx < n_rows) ? bias_m[idx] : '0;
            end
            send_tile(BIAS_STREAM, tile);
        end
        for (int r = 0; r < n_rows; r++) begin
            for (int t = 0; t < col_tiles; t++) begin
                for (int i = 0; i < gemv_pkg::TILE_LEN; i++) begin
                    idx = t * gemv_pkg::TILE_LEN + i;
                    tile[i] = (idx < n_cols) ? w_m[r][idx] : rand_data();
                end
                send_tile(W_STREAM, tile);
            end
        end
        collect_y(row_tiles);
        // Done shows for one cycle only after the last transfer edge
        @(negedge clk);
        check_flag(done, 1'b1, "done after the last y transfer");
        check_flag(y_valid, 1'b0, "y_valid after the last y transfer");
        @(posedge clk);
        #2;
        @(negedge clk);
        check_flag(done, 1'b0, "done on the second cycle");
        @(posedge clk);
        #2;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the jobs did not finish within %0d cycles", CYCLE_LIMIT);
        $display("test failed");
        $fatal(1, "Simulation stopped by the cycle limit");
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        rows       = '0;
        cols       = '0;
        x_valid    = 1'b0;
        x_tile     = '0;
        bias_valid = 1'b0;
        bias_tile  = '0;
        w_valid    = 1'b0;
        w_tile     = '0;
        y_ready    = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_flag(x_ready, 1'b0, "x_ready before start");
            check_flag(bias_ready, 1'b0, "bias_ready before start");
            check_flag(w_ready, 1'b0, "w_ready before start");
            check_flag(y_valid, 1'b0, "y_valid before start");
            check_flag(done, 1'b0, "done before start");
        end
        @(posedge clk);
        #2;
        // Fixed corner jobs come first and random sizes follow
        run_job(16, 16);
        run_job(13, 21);
        run_job(32, 32);
        run_job(1, 1);
        run_job(7, 8);
        for (int j = 5; j < NUM_JOBS; j++) begin
            if (j % 2 == 0) begin
                run_job(1 + rand_below(32), 8 * (1 + rand_below(4)));
            end else begin
                run_job(1 + rand_below(32), 1 + rand_below(32));
            end
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- gemv_top.sv
`timescale 1ns/10ps
`default_nettype none

module gemv_top (
    input  wire logic                  clk,
    input  wire logic                  rst,
    // Job control
    input  wire logic                  start,
    input  wire gemv_pkg::dim_t        rows,
    input  wire gemv_pkg::dim_t        cols,
    output logic                       done,
    // x stream
    input  wire logic                  x_valid,
    input  wire gemv_pkg::tile_t       x_tile,
    output logic                       x_ready,
    // bias stream
    input  wire logic                  bias_valid,
    input  wire gemv_pkg::tile_t       bias_tile,
    output logic                       bias_ready,
    // Weight stream
    input  wire logic                  w_valid,
    input  wire gemv_pkg::tile_t       w_tile,
    output logic                       w_ready,
    // y stream
    output logic                       y_valid,
    output gemv_pkg::acc_tile_t        y_tile,
    output gemv_pkg::tile_idx_t        y_tile_idx,
    input  wire logic                  y_ready
);

    logic                x_wr;
    logic                bias_wr;
    logic                w_xfer;
    logic                w_last;
    gemv_pkg::tile_idx_t tile_idx;
    gemv_pkg::row_t      row_idx;
    gemv_pkg::lane_cnt_t lane_cnt;
    gemv_pkg::tile_t     x_rd_tile;
    gemv_pkg::acc_t      sum;
    logic                sum_valid;
    gemv_pkg::row_t      sum_row;
    logic                sum_last;

    gemv_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .rows       (rows),
        .cols       (cols),
        .x_valid    (x_valid),
        .x_ready    (x_ready),
        .bias_valid (bias_valid),
        .bias_ready (bias_ready),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .y_ready    (y_ready),
        .y_valid    (y_valid),
        .y_tile_idx (y_tile_idx),
        .done       (done),
        .x_wr       (x_wr),
        .bias_wr    (bias_wr),
        .w_xfer     (w_xfer),
        .tile_idx   (tile_idx),
        .row_idx    (row_idx),
        .lane_cnt   (lane_cnt),
        .w_last     (w_last),
        .sum_last   (sum_last)
    );

    // Same tile index writes x while loading and reads it during compute
    gemv_x_buffer i_x_buffer (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (x_wr),
        .wr_tile (tile_idx),
        .wr_data (x_tile),
        .rd_tile (tile_idx),
        .rd_data (x_rd_tile)
    );

    gemv_dot_tile i_dot_tile (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (w_xfer),
        .w_tile    (w_tile),
        .x_tile    (x_rd_tile),
        .lane_cnt  (lane_cnt),
        .row_in    (row_idx),
        .last_in   (w_last),
        .sum       (sum),
        .sum_valid (sum_valid),
        .sum_row   (sum_row),
        .sum_last  (sum_last)
    );

    gemv_acc_bank i_acc_bank (
        .clk           (clk),
        .rst           (rst),
        .bias_wr       (bias_wr),
        .bias_tile_idx (tile_idx),
        .bias_tile     (bias_tile),
        .sum_valid     (sum_valid),
        .sum_row       (sum_row),
        .sum           (sum),
        .rd_tile       (y_tile_idx),
        .rd_data       (y_tile)
    );

endmodule

`default_nettype wire

//--- gemv_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module gemv_ctrl (
    input  wire logic                  clk,
    input  wire logic                  rst,
    // Job control
    input  wire logic                  start,
    input  wire gemv_pkg::dim_t        rows,
    input  wire gemv_pkg::dim_t        cols,
    // Stream handshakes
    input  wire logic                  x_valid,
    output logic                       x_ready,
    input  wire logic                  bias_valid,
    output logic                       bias_ready,
    input  wire logic                  w_valid,
    output logic                       w_ready,
    input  wire logic                  y_ready,
    output logic                       y_valid,
    output gemv_pkg::tile_idx_t        y_tile_idx,
    output logic                       done,
    // Datapath control
    output logic                       x_wr,
    output logic                       bias_wr,
    output logic                       w_xfer,
    output gemv_pkg::tile_idx_t        tile_idx,
    output gemv_pkg::row_t             row_idx,
    output gemv_pkg::lane_cnt_t        lane_cnt,
    output logic                       w_last,
    input  wire logic                  sum_last
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD_X,
        S_LOAD_BIAS,
        S_COMPUTE,
        S_DRAIN,
        S_OUTPUT,
        S_DONE
    } state_t;

    state_t state;

    // Job geometry derived from rows and cols
    gemv_pkg::tile_idx_t last_col_tile;
    gemv_pkg::tile_idx_t last_row_tile;
    gemv_pkg::row_t      last_row;
    gemv_pkg::lane_cnt_t col_rem;

    logic y_xfer;

    assign last_col_tile = gemv_pkg::tile_idx_t'((cols - 1'b1) / gemv_pkg::TILE_LEN);
    assign last_row_tile = gemv_pkg::tile_idx_t'((rows - 1'b1) / gemv_pkg::TILE_LEN);
    assign last_row      = gemv_pkg::row_t'(rows - 1'b1);
    assign col_rem       = gemv_pkg::lane_cnt_t'(cols % gemv_pkg::TILE_LEN);

    // Only the last column tile of a row can be partial
    assign lane_cnt = (tile_idx == last_col_tile && col_rem != '0) ?
                      col_rem : gemv_pkg::lane_cnt_t'(gemv_pkg::TILE_LEN);

    // Transfers on each stream
    assign x_wr    = x_valid && x_ready;
    assign bias_wr = bias_valid && bias_ready;
    assign w_xfer  = w_valid && w_ready;
    assign y_xfer  = y_valid && y_ready;

    // Final weight tile of the job
    assign w_last = (state == S_COMPUTE) && (row_idx == last_row) &&
                    (tile_idx == last_col_tile);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            x_ready    <= 1'b0;
            bias_ready <= 1'b0;
            w_ready    <= 1'b0;
            y_valid    <= 1'b0;
            done       <= 1'b0;
            tile_idx   <= '0;
            row_idx    <= '0;
            y_tile_idx <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state    <= S_LOAD_X;
                        x_ready  <= 1'b1;
                        tile_idx <= '0;
                    end
                end

                S_LOAD_X: begin
                    if (x_wr) begin
                        if (tile_idx == last_col_tile) begin
                            state      <= S_LOAD_BIAS;
                            x_ready    <= 1'b0;
                            bias_ready <= 1'b1;
                            tile_idx   <= '0;
                        end else begin
                            tile_idx <= tile_idx + 1'b1;
                        end
                    end
                end

                S_LOAD_BIAS: begin
                    if (bias_wr) begin
                        if (tile_idx == last_row_tile) begin
                            state      <= S_COMPUTE;
                            bias_ready <= 1'b0;
                            w_ready    <= 1'b1;
                            tile_idx   <= '0;
                            row_idx    <= '0;
                        end else begin
                            tile_idx <= tile_idx + 1'b1;
                        end
                    end
                end

                S_COMPUTE: begin
                    // Walk the column tiles of each row in turn
                    if (w_xfer) begin
                        if (w_last) begin
                            state   <= S_DRAIN;
                            w_ready <= 1'b0;
                        end else if (tile_idx == last_col_tile) begin
                            tile_idx <= '0;
                            row_idx  <= row_idx + 1'b1;
                        end else begin
                            tile_idx <= tile_idx + 1'b1;
                        end
                    end
                end

                S_DRAIN: begin
                    // The last sum lands in the bank at this edge
                    if (sum_last) begin
                        state      <= S_OUTPUT;
                        y_valid    <= 1'b1;
                        y_tile_idx <= '0;
                    end
                end

                S_OUTPUT: begin
                    if (y_xfer) begin
                        if (y_tile_idx == last_row_tile) begin
                            state   <= S_DONE;
                            y_valid <= 1'b0;
                            done    <= 1'b1;
                        end else begin
                            y_tile_idx <= y_tile_idx + 1'b1;
                        end
                    end
                end

                S_DONE: begin
                    state <= S_IDLE;
                    done  <= 1'b0;
                end

                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- gemv_acc_bank.sv
`timescale 1ns/10ps
`default_nettype none

module gemv_acc_bank (
    input  wire logic                  clk,
    input  wire logic                  rst,
    // Bias seeding, one tile of rows per write
    input  wire logic                  bias_wr,
    input  wire gemv_pkg::tile_idx_t   bias_tile_idx,
    input  wire gemv_pkg::tile_t       bias_tile,
    // Tile sums from the dot pipeline
    input  wire logic                  sum_valid,
    input  wire gemv_pkg::row_t        sum_row,
    input  wire gemv_pkg::acc_t        sum,
    // Readout of one tile of accumulators
    input  wire gemv_pkg::tile_idx_t   rd_tile,
    output gemv_pkg::acc_tile_t        rd_data
);

    // One accumulator per supported row
    gemv_pkg::acc_t acc [gemv_pkg::MAX_ROWS];

    // Bias writes and sums never overlap since they belong to different phases
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < gemv_pkg::MAX_ROWS; r++) begin
                acc[r] <= '0;
            end
        end else if (bias_wr) begin
            // Seed TILE_LEN consecutive rows with the widened bias
            for (int i = 0; i < gemv_pkg::TILE_LEN; i++) begin
                acc[gemv_pkg::row_t'(int'(bias_tile_idx) * gemv_pkg::TILE_LEN + i)] <=
                    gemv_pkg::acc_t'(bias_tile[i]);
            end
        end else if (sum_valid) begin
            // Read, add and write in the same edge
            // so back to back sums to one row stack up
            acc[sum_row] <= acc[sum_row] + sum;
        end
    end

    // Combinational readout keeps y_tile stable while the index holds
    always_comb begin
        for (int i = 0; i < gemv_pkg::TILE_LEN; i++) begin
            rd_data[i] = acc[gemv_pkg::row_t'(int'(rd_tile) * gemv_pkg::TILE_LEN + i)];
        end
    end

endmodule

`default_nettype wire

//--- gemv_dot_tile.sv
`timescale 1ns/10ps
`default_nettype none

module gemv_dot_tile (
    input  wire logic                  clk,
    input  wire logic                  rst,
    // Weight tile with its matching x tile
    input  wire logic                  in_valid,
    input  wire gemv_pkg::tile_t       w_tile,
    input  wire gemv_pkg::tile_t       x_tile,
    input  wire gemv_pkg::lane_cnt_t   lane_cnt,
    input  wire gemv_pkg::row_t        row_in,
    input  wire logic                  last_in,
    // Tile sum with its tags two cycles later
    output gemv_pkg::acc_t             sum,
    output logic                       sum_valid,
    output gemv_pkg::row_t             sum_row,
    output logic                       sum_last
);

    // Stage 1 holds the masked lane products
    logic signed [gemv_pkg::PROD_W-1:0] prod [gemv_pkg::TILE_LEN];
    logic                               s1_valid;
    logic                               s1_last;
    gemv_pkg::row_t                     s1_row;

    // Adder tree over the stage 1 products
    gemv_pkg::acc_t                     prod_sum;

    // Valid and last travel together through both stages
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            s1_last   <= 1'b0;
            sum_valid <= 1'b0;
            sum_last  <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            s1_last   <= in_valid && last_in;
            sum_valid <= s1_valid;
            sum_last  <= s1_valid && s1_last;
        end
    end

    // Lanes at or past lane_cnt contribute nothing
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_row <= row_in;
            for (int i = 0; i < gemv_pkg::TILE_LEN; i++) begin
                if (i < lane_cnt) begin
                    prod[i] <= $signed(w_tile[i]) * $signed(x_tile[i]);
                end else begin
                    prod[i] <= '0;
                end
            end
        end
    end

    // Products are sign extended into the accumulator width
    always_comb begin
        prod_sum = '0;
        for (int i = 0; i < gemv_pkg::TILE_LEN; i++) begin
            prod_sum = prod_sum + prod[i];
        end
    end

    // Stage 2 registers the sum with its row tag
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            sum     <= prod_sum;
            sum_row <= s1_row;
        end
    end

endmodule

`default_nettype wire

//--- gemv_x_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module gemv_x_buffer (
    input  wire logic                  clk,
    input  wire logic                  rst,
    // Write side fed by the x stream
    input  wire logic                  wr_en,
    input  wire gemv_pkg::tile_idx_t   wr_tile,
    input  wire gemv_pkg::tile_t       wr_data,
    // Read side follows the weight tile index
    input  wire gemv_pkg::tile_idx_t   rd_tile,
    output gemv_pkg::tile_t            rd_data
);

    // One entry per column tile of x
    gemv_pkg::tile_t mem [gemv_pkg::MAX_TILES];

    // Whole tile is written at the x transfer edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int t = 0; t < gemv_pkg::MAX_TILES; t++) begin
                mem[t] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_tile] <= wr_data;
        end
    end

    // Combinational read so lane i lines up with column tile*TILE_LEN+i
    // in the same cycle the weight tile is accepted
    assign rd_data = mem[rd_tile];

endmodule

`default_nettype wire

//--- gemv_pkg.sv
`default_nettype none

package gemv_pkg;

    // Element and tile geometry
    localparam int DATA_W   = 8;
    localparam int TILE_LEN = 8;

    // Largest matrix the unit can hold
    localparam int MAX_ROWS = 32;
    localparam int MAX_COLS = 32;

    // Arithmetic widths
    localparam int PROD_W = 2 * DATA_W;
    localparam int ACC_W  = 32;

    // Column tiles needed for the widest x vector
    localparam int MAX_TILES = MAX_COLS / TILE_LEN;

    // Signed scalars
    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // Tiles are packed so they can travel on a single port
    typedef data_t [TILE_LEN-1:0] tile_t;
    typedef acc_t  [TILE_LEN-1:0] acc_tile_t;

    // Rows or cols value in the range 1 to MAX
    typedef logic [$clog2(MAX_COLS+1)-1:0] dim_t;

    // Index types
    typedef logic [$clog2(MAX_ROWS)-1:0]  row_t;
    typedef logic [$clog2(MAX_TILES)-1:0] tile_idx_t;

    // Number of live lanes in a tile, 0 up to TILE_LEN
    typedef logic [$clog2(TILE_LEN+1)-1:0] lane_cnt_t;

endpackage

`default_nettype wire
